//--- Makefile
SRCS := $(shell cat vlog.f)

all: run

obj_dir/Vfedp_tb: vlog.f $(SRCS)
	verilator --binary --timing --timescale 1ns/1ps -j 0 \
	    --top-module fedp_tb -f vlog.f

run: obj_dir/Vfedp_tb
	./obj_dir/Vfedp_tb > sim.log 2>&1 || true
	cat sim.log
	grep -q "Simulation PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean

//--- common/fedp_pkg.sv
package fedp_pkg;

    // ----------------------------------------
    // Shared widths
    // ----------------------------------------
    // Lanes per request
    localparam int FEDP_LANES  = 2;
    // Accumulator frame width, two's complement
    localparam int FEDP_WA     = 30;
    // Signed internal exponent width
    localparam int FEDP_EXP_W  = 10;
    // Integer addend bits above bit 24
    localparam int FEDP_C_HI_W = 7;

    // ----------------------------------------
    // Data path structs
    // ----------------------------------------
    // Special-value summary carried down the pipe
    typedef struct packed {
        logic is_nan;
        logic is_inf;
        logic sign;
    } fedp_excep_t;

    // One lane, bf16 or int8 in the low byte
    typedef struct packed {
        logic [15:0] a;
        logic [15:0] b;
    } fedp_lane_t;

    // Host configuration
    typedef struct packed {
        logic        is_int;
        logic [31:0] cval;
    } fedp_cfg_t;

    // Per-lane multiplier result
    typedef struct packed {
        logic [15:0]                  sig;
        logic signed [FEDP_EXP_W-1:0] exp;
        logic                         sign;
        logic                         zero;
        logic signed [15:0]           iprod;
    } fedp_prod_lane_t;

    typedef struct packed {
        fedp_prod_lane_t [FEDP_LANES-1:0] lanes;
        fedp_excep_t                      excep;
    } fedp_prod_t;

    // Alignment stage result
    typedef struct packed {
        logic [FEDP_WA-1:0]     acc_sig;
        logic [FEDP_EXP_W-1:0]  max_exp;
        logic                   sticky;
        logic [FEDP_C_HI_W-1:0] cval_hi;
        logic                   is_int;
        fedp_excep_t            excep;
    } fedp_acc_t;

endpackage

//--- design/fedp_cfg_regs.sv
`timescale 1ns/1ps

module fedp_cfg_regs (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                cfg_we,
    input  fedp_pkg::fedp_cfg_t cfg_data,
    output fedp_pkg::fedp_cfg_t cfg
);

    // ----------------------------------------
    // Mode and addend register
    // ----------------------------------------
    // Reset value is float mode with c = +0
    // A write becomes visible to requests from the next cycle
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cfg <= '0;
        end else if (cfg_we) begin
            // Held until the host writes again
            cfg <= cfg_data;
        end
    end

endmodule

//--- design/fedp_top.sv
`timescale 1ns/1ps

module fedp_top #(
    parameter int WA     = fedp_pkg::FEDP_WA,
    parameter int EXP_W  = fedp_pkg::FEDP_EXP_W,
    parameter int C_HI_W = fedp_pkg::FEDP_C_HI_W,
    parameter int LANES  = fedp_pkg::FEDP_LANES
) (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 cfg_we,
    input  fedp_pkg::fedp_cfg_t  cfg_data,
    input  logic                 in_valid,
    input  fedp_pkg::fedp_lane_t in_lanes [LANES],
    output logic                 out_valid,
    output logic [31:0]          result
);
    import fedp_pkg::*;

    fedp_cfg_t  cfg;
    fedp_cfg_t  cfg_q;
    fedp_prod_t prod;
    fedp_acc_t  acc;
    logic       mul_valid;
    logic       acc_valid;

    // ----------------------------------------
    // Configuration
    // ----------------------------------------
    fedp_cfg_regs u_cfg_regs (
        .clk     (clk),
        .arst_n  (arst_n),
        .cfg_we  (cfg_we),
        .cfg_data(cfg_data),
        .cfg     (cfg)
    );

    // ----------------------------------------
    // Three-stage pipeline
    // ----------------------------------------
    // Multiply, then align and accumulate
    fedp_mul #(
        .LANES(LANES)
    ) u_mul (
        .clk      (clk),
        .arst_n   (arst_n),
        .in_valid (in_valid),
        .in_lanes (in_lanes),
        .cfg      (cfg),
        .mul_valid(mul_valid),
        .prod     (prod),
        .cfg_q    (cfg_q)
    );

    fedp_align #(
        .WA    (WA),
        .EXP_W (EXP_W),
        .C_HI_W(C_HI_W)
    ) u_align (
        .clk      (clk),
        .arst_n   (arst_n),
        .mul_valid(mul_valid),
        .prod     (prod),
        .cfg_q    (cfg_q),
        .acc_valid(acc_valid),
        .acc      (acc)
    );

    // Normalize, round and pack
    fedp_norm_round #(
        .WA    (WA),
        .EXP_W (EXP_W),
        .C_HI_W(C_HI_W)
    ) u_norm_round (
        .clk      (clk),
        .arst_n   (arst_n),
        .acc_valid(acc_valid),
        .acc      (acc),
        .out_valid(out_valid),
        .result   (result)
    );

endmodule

//--- fedp/fedp_align.sv
`timescale 1ns/1ps

module fedp_align #(
    parameter int WA     = 30,
    parameter int EXP_W  = 10,
    parameter int C_HI_W = 7
) (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 mul_valid,
    input  fedp_pkg::fedp_prod_t prod,
    input  fedp_pkg::fedp_cfg_t  cfg_q,
    output logic                 acc_valid,
    output fedp_pkg::fedp_acc_t  acc
);
    import fedp_pkg::*;

    // Products plus the addend
    localparam int NT     = FEDP_LANES + 1;
    // Top bit of the largest term, leaves room for sign and carries
    localparam int TOP    = WA - 4;
    localparam int C_LO_W = 32 - C_HI_W;

    logic [WA-1:0]           t_base [NT];
    logic signed [EXP_W-1:0] t_exp  [NT];
    logic                    t_sign [NT];
    logic                    t_zero [NT];
    logic signed [EXP_W-1:0] max_top;
    logic [WA-1:0]           f_sum;
    logic                    f_sticky;
    logic [WA-1:0]           i_sum;
    fedp_acc_t               acc_d;

    // ----------------------------------------
    // Term setup
    // ----------------------------------------
    // Each term left-aligned at TOP, t_exp is the exponent of that bit
    always_comb begin
        for (int i = 0; i < FEDP_LANES; i++) begin
            t_base[i] = WA'(prod.lanes[i].sig) << (TOP - 15);
            t_exp[i]  = prod.lanes[i].exp + EXP_W'(1);
            t_sign[i] = prod.lanes[i].sign;
            t_zero[i] = prod.lanes[i].zero;
        end
        t_base[NT-1] = WA'({1'b1, cfg_q.cval[22:0]}) << (TOP - 23);
        t_exp[NT-1]  = EXP_W'(cfg_q.cval[30:23]);
        t_sign[NT-1] = cfg_q.cval[31];
        t_zero[NT-1] = (cfg_q.cval[30:23] == 8'h00);
    end

    // Largest exponent among the nonzero terms
    always_comb begin
        max_top = {1'b1, {(EXP_W-1){1'b0}}};
        for (int i = 0; i < NT; i++) begin
            if (!t_zero[i] && (t_exp[i] > max_top)) begin
                max_top = t_exp[i];
            end
        end
    end

    // ----------------------------------------
    // Alignment and float accumulation
    // ----------------------------------------
    always_comb begin : float_acc
        logic [EXP_W-1:0] sh;
        logic [WA-1:0]    aligned;
        logic [WA-1:0]    low;

        f_sum    = '0;
        f_sticky = 1'b0;
        for (int i = 0; i < NT; i++) begin
            sh  = max_top - t_exp[i];
            low = '0;
            if (t_zero[i]) begin
                aligned = '0;
            end else if (sh >= EXP_W'(WA)) begin
                // Shifted out entirely
                aligned  = '0;
                f_sticky = f_sticky | (|t_base[i]);
            end else begin
                {aligned, low} = {t_base[i], {WA{1'b0}}} >> sh;
                f_sticky = f_sticky | (|low);
            end
            f_sum = f_sum + (t_sign[i] ? -aligned : aligned);
        end
    end

    // Integer path, products plus low part of c
    always_comb begin
        i_sum = WA'(cfg_q.cval[C_LO_W-1:0]);
        for (int i = 0; i < FEDP_LANES; i++) begin
            i_sum = i_sum + WA'($signed(prod.lanes[i].iprod));
        end
    end

    always_comb begin
        acc_d.acc_sig = cfg_q.is_int ? i_sum : f_sum;
        // Exponent seen when the leading one sits at bit WA-1
        acc_d.max_exp = max_top + EXP_W'(WA - 1 - TOP);
        acc_d.sticky  = cfg_q.is_int ? 1'b0 : f_sticky;
        acc_d.cval_hi = cfg_q.cval[31 -: C_HI_W];
        acc_d.is_int  = cfg_q.is_int;
        acc_d.excep   = prod.excep;
    end

    // ----------------------------------------
    // Stage register
    // ----------------------------------------
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            acc_valid <= 1'b0;
        end else begin
            acc_valid <= mul_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (mul_valid) begin
            acc <= acc_d;
        end
    end

endmodule

//--- fedp/fedp_lzc.sv
`timescale 1ns/1ps

module fedp_lzc #(
    parameter int N = 30
) (
    input  logic [N-1:0]         data,
    output logic [$clog2(N)-1:0] count
);

    // ----------------------------------------
    // Leading zero count
    // ----------------------------------------
    // Scan upward so the highest set bit is the last to win
    // All-zero input gives N, truncated when N is a power of two
    // so the caller checks for zero itself
    always_comb begin
        count = ($clog2(N))'(N);
        for (int i = 0; i < N; i++) begin
            if (data[i]) begin
                count = ($clog2(N))'(N - 1 - i);
            end
        end
    end

endmodule

//--- fedp/fedp_mul.sv
`timescale 1ns/1ps

module fedp_mul #(
    parameter int LANES = 2
) (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 in_valid,
    input  fedp_pkg::fedp_lane_t in_lanes [LANES],
    input  fedp_pkg::fedp_cfg_t  cfg,
    output logic                 mul_valid,
    output fedp_pkg::fedp_prod_t prod,
    output fedp_pkg::fedp_cfg_t  cfg_q
);
    import fedp_pkg::*;

    fedp_prod_t prod_d;

    // Addend classification, c takes part in the exception merge
    logic c_nan;
    logic c_inf;
    assign c_nan = (cfg.cval[30:23] == 8'hFF) && (cfg.cval[22:0] != '0);
    assign c_inf = (cfg.cval[30:23] == 8'hFF) && (cfg.cval[22:0] == '0);

    // ----------------------------------------
    // Lane products and exception merge
    // ----------------------------------------
    always_comb begin : lane_mul
        logic [7:0]        a_exp;
        logic [7:0]        b_exp;
        logic              a_zero;
        logic              b_zero;
        logic              a_inf;
        logic              b_inf;
        logic              l_nan;
        logic              any_nan;
        logic              pos_inf;
        logic              neg_inf;
        logic signed [7:0] ia;
        logic signed [7:0] ib;

        prod_d  = '0;
        any_nan = c_nan;
        pos_inf = c_inf & ~cfg.cval[31];
        neg_inf = c_inf & cfg.cval[31];
        for (int i = 0; i < LANES; i++) begin
            a_exp  = in_lanes[i].a[14:7];
            b_exp  = in_lanes[i].b[14:7];
            // Subnormals flush to zero
            a_zero = (a_exp == 8'h00);
            b_zero = (b_exp == 8'h00);
            a_inf  = (a_exp == 8'hFF) && (in_lanes[i].a[6:0] == '0);
            b_inf  = (b_exp == 8'hFF) && (in_lanes[i].b[6:0] == '0);
            // NaN operand, or Inf times zero
            l_nan  = ((a_exp == 8'hFF) && !a_inf) || ((b_exp == 8'hFF) && !b_inf)
                   || (a_inf && b_zero) || (a_zero && b_inf);

            prod_d.lanes[i].sign = in_lanes[i].a[15] ^ in_lanes[i].b[15];
            prod_d.lanes[i].zero = a_zero | b_zero;
            // Hidden-one significands, 8x8 into 16 bits
            if (!(a_zero || b_zero)) begin
                prod_d.lanes[i].sig = {1'b1, in_lanes[i].a[6:0]} * {1'b1, in_lanes[i].b[6:0]};
            end
            // Biased exponent of the 1.x product
            prod_d.lanes[i].exp = FEDP_EXP_W'(a_exp) + FEDP_EXP_W'(b_exp) - FEDP_EXP_W'(127);

            // Integer mode uses the low byte as int8
            ia = in_lanes[i].a[7:0];
            ib = in_lanes[i].b[7:0];
            prod_d.lanes[i].iprod = ia * ib;

            any_nan = any_nan | l_nan;
            if ((a_inf || b_inf) && !l_nan) begin
                if (prod_d.lanes[i].sign) begin
                    neg_inf = 1'b1;
                end else begin
                    pos_inf = 1'b1;
                end
            end
        end

        // Opposite infinities cancel into NaN
        prod_d.excep.is_nan = ~cfg.is_int & (any_nan | (pos_inf & neg_inf));
        prod_d.excep.is_inf = ~cfg.is_int & ~any_nan & (pos_inf ^ neg_inf);
        prod_d.excep.sign   = neg_inf;
    end

    // ----------------------------------------
    // Stage register
    // ----------------------------------------
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mul_valid <= 1'b0;
        end else begin
            mul_valid <= in_valid;
        end
    end

    // Mode and c travel with the request from here on
    always_ff @(posedge clk) begin
        if (in_valid) begin
            prod  <= prod_d;
            cfg_q <= cfg;
        end
    end

endmodule

//--- fedp/fedp_norm_round.sv
`timescale 1ns/1ps

module fedp_norm_round #(
    parameter int WA     = 30,
    parameter int EXP_W  = 10,
    parameter int C_HI_W = 7
) (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                acc_valid,
    input  fedp_pkg::fedp_acc_t acc,
    output logic                out_valid,
    output logic [31:0]         result
);

    logic                    sum_sign;
    logic [WA-1:0]           abs_sum;
    logic                    zero_sum;
    logic [$clog2(WA)-1:0]   lz_count;
    logic [WA-1:0]           shifted;
    logic [23:0]             norm_man;
    logic                    guard_bit;
    logic                    round_bit;
    logic                    sticky_bit;
    logic                    round_up;
    logic [24:0]             rounded;
    logic                    carry_out;
    logic [22:0]             final_man;
    logic signed [EXP_W-1:0] norm_exp;
    logic signed [EXP_W-1:0] final_exp;
    logic [31:0]             fp_result;
    logic [C_HI_W-1:0]       int_hi;
    logic [31:0]             int_result;

    // ----------------------------------------
    // Magnitude and normalization
    // ----------------------------------------
    assign sum_sign = acc.acc_sig[WA-1];
    assign abs_sum  = sum_sign ? -acc.acc_sig : acc.acc_sig;
    assign zero_sum = ~|abs_sum;

    fedp_lzc #(
        .N(WA)
    ) u_lzc (
        .data (abs_sum),
        .count(lz_count)
    );

    // Leading one moves to bit WA-1
    assign shifted  = abs_sum << lz_count;
    assign norm_exp = $signed(acc.max_exp) - EXP_W'(lz_count);

    // ----------------------------------------
    // Round to nearest even
    // ----------------------------------------
    // 24-bit significand, then guard, round and sticky below it
    assign norm_man   = shifted[WA-1 -: 24];
    assign guard_bit  = shifted[WA-25];
    assign round_bit  = shifted[WA-26];
    assign sticky_bit = (|shifted[WA-27:0]) | acc.sticky;
    // Ties go up only when the kept LSB is odd
    assign round_up   = guard_bit & (round_bit | sticky_bit | norm_man[0]);

    assign rounded   = {1'b0, norm_man} + 25'(round_up);
    // 1.11..1 rounding up wraps to 10.00..0, fraction is zero either way
    assign carry_out = rounded[24];
    assign final_man = rounded[22:0];
    assign final_exp = norm_exp + EXP_W'(carry_out);

    // ----------------------------------------
    // fp32 packing
    // ----------------------------------------
    always_comb begin
        if (acc.excep.is_nan) begin
            // Canonical quiet NaN
            fp_result = 32'h7FC0_0000;
        end else if (acc.excep.is_inf) begin
            fp_result = {acc.excep.sign, 8'hFF, 23'd0};
        end else if (zero_sum || (final_exp <= 0)) begin
            // Underflow goes to signed zero, no subnormals
            fp_result = {sum_sign, 31'd0};
        end else if (final_exp >= 255) begin
            fp_result = {sum_sign, 8'hFF, 23'd0};
        end else begin
            fp_result = {sum_sign, final_exp[7:0], final_man};
        end
    end

    // ----------------------------------------
    // Integer completion
    // ----------------------------------------
    // Sign-extended accumulator bits above 24 plus c bits 31..25
    assign int_hi     = C_HI_W'($signed(acc.acc_sig[WA-1:32-C_HI_W])) + acc.cval_hi;
    assign int_result = {int_hi, acc.acc_sig[31-C_HI_W:0]};

    // Output register
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
            result    <= '0;
        end else begin
            out_valid <= acc_valid;
            if (acc_valid) begin
                result <= acc.is_int ? int_result : fp_result;
            end
        end
    end

endmodule

//--- testbench/fedp_tb.sv
`timescale 1ns/1ps

module fedp_tb;
    import fedp_pkg::*;

    // One table row: mode, addend, two lanes and the expected result
    typedef struct packed {
        logic        is_int;
        logic [31:0] cval;
        logic [15:0] a0;
        logic [15:0] b0;
        logic [15:0] a1;
        logic [15:0] b1;
        logic [31:0] expv;
    } row_t;

    logic       clk;
    logic       arst_n;
    logic       cfg_we;
    fedp_cfg_t  cfg_data;
    logic       in_valid;
    fedp_lane_t in_lanes [FEDP_LANES];
    logic       out_valid;
    logic [31:0] result;

    row_t        rows [$];
    logic [31:0] exp_q [$];
    int          issue_q [$];
    int          cyc = 0;

    fedp_top u_fedp_top (
        .clk      (clk),
        .arst_n   (arst_n),
        .cfg_we   (cfg_we),
        .cfg_data (cfg_data),
        .in_valid (in_valid),
        .in_lanes (in_lanes),
        .out_valid(out_valid),
        .result   (result)
    );

    // 40 ns clock
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Cycle count used for the latency check
    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    // ----------------------------------------
    // Helpers
    // ----------------------------------------
    task automatic abort_run();
        $display("Simulation FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expv);
        if (got !== expv) begin
            $display("[ERROR] t=%0t %s: got %h, expected %h", $time, name, got, expv);
            abort_run();
        end
    endtask

    task automatic add_row(input logic is_int, input logic [31:0] cval,
                           input logic [15:0] a0, input logic [15:0] b0,
                           input logic [15:0] a1, input logic [15:0] b1,
                           input logic [31:0] expv);
        rows.push_back({is_int, cval, a0, b0, a1, b1, expv});
    endtask

    // Two int8 products plus c, wrapped to 32 bits
    function automatic logic [31:0] int_dot_ref(input logic [7:0] a0, input logic [7:0] b0,
                                                input logic [7:0] a1, input logic [7:0] b1,
                                                input logic [31:0] c);
        logic signed [31:0] p0;
        logic signed [31:0] p1;
        p0 = 32'($signed(a0)) * 32'($signed(b0));
        p1 = 32'($signed(a1)) * 32'($signed(b1));
        return p0 + p1 + c;
    endfunction

    // ----------------------------------------
    // Output monitor
    // ----------------------------------------
    always @(negedge clk) begin : monitor
        logic [31:0] expv;
        int          issued;
        if (!arst_n) begin
            // Nothing may come out while in reset
            check_value("out_valid", 32'(out_valid), 32'd0);
            check_value("result", result, 32'd0);
        end else if (out_valid) begin
            if (exp_q.size() == 0) begin
                $display("out_valid rose with no request pending at t=%0t", $time);
                abort_run();
            end
            expv   = exp_q.pop_front();
            issued = issue_q.pop_front();
            check_value("result", result, expv);
            check_value("out_valid latency", 32'(cyc - issued), 32'd3);
        end
    end

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------
    initial begin : stimulus
        row_t        row;
        logic [7:0]  ra0;
        logic [7:0]  rb0;
        logic [7:0]  ra1;
        logic [7:0]  rb1;
        logic [31:0] rc;
        int          waits;

        void'($urandom(63965));
        arst_n      = 1'b0;
        cfg_we      = 1'b0;
        cfg_data    = '0;
        in_valid    = 1'b0;
        in_lanes[0] = '0;
        in_lanes[1] = '0;

        // Integer rows, including carries and borrows across bit 25
        add_row(1'b1, 32'd100,      16'h0005, 16'h00FD, 16'h00F9, 16'h0009, 32'h0000_0016);
        add_row(1'b1, 32'h01FF_FFFF, 16'h0080, 16'h0080, 16'h007F, 16'h007F, 32'h0200_7F00);
        add_row(1'b1, 32'h8000_0000, 16'h00FE, 16'h0003, 16'h0004, 16'h00FB, 32'h7FFF_FFE6);
        add_row(1'b1, 32'hFFFF_FFFF, 16'h0001, 16'h0001, 16'h0000, 16'h0000, 32'h0000_0000);
        add_row(1'b1, 32'h0200_0010, 16'h0080, 16'h007F, 16'h0080, 16'h007F, 32'h01FF_8110);
        // Exact float sums, last one cancels to +0
        add_row(1'b0, 32'h4080_0000, 16'h3FC0, 16'h4000, 16'h4040, 16'hBF00, 32'h40B0_0000);
        add_row(1'b0, 32'hC000_0000, 16'h3F80, 16'h3F80, 16'h3F00, 16'h3F00, 32'hBF40_0000);
        add_row(1'b0, 32'h0000_0000, 16'h3F80, 16'h4000, 16'hBF80, 16'h4000, 32'h0000_0000);
        // Ties: even below, odd below, sticky above, negative odd below
        add_row(1'b0, 32'h3F80_0000, 16'h3980, 16'h3980, 16'h0000, 16'h0000, 32'h3F80_0000);
        add_row(1'b0, 32'h3F80_0001, 16'h3980, 16'h3980, 16'h0000, 16'h0000, 32'h3F80_0002);
        add_row(1'b0, 32'h3F80_0000, 16'h3980, 16'h3980, 16'h3580, 16'h3580, 32'h3F80_0001);
        add_row(1'b0, 32'hBF80_0001, 16'hB980, 16'h3980, 16'h0000, 16'h0000, 32'hBF80_0002);
        // Odd tie on all-ones fraction carries into the exponent
        add_row(1'b0, 32'h3FFF_FFFF, 16'h3980, 16'h3980, 16'h0000, 16'h0000, 32'h4000_0000);

        // Random integer rows
        for (int r = 0; r < 24; r++) begin
            ra0 = 8'($urandom());
            rb0 = 8'($urandom());
            ra1 = 8'($urandom());
            rb1 = 8'($urandom());
            rc  = $urandom();
            add_row(1'b1, rc, {8'h00, ra0}, {8'h00, rb0}, {8'h00, ra1}, {8'h00, rb1},
                    int_dot_ref(ra0, rb0, ra1, rb1, rc));
        end

        // Special values
        add_row(1'b0, 32'h0000_0000, 16'h7FC0, 16'h3F80, 16'h0000, 16'h0000, 32'h7FC0_0000);
        add_row(1'b0, 32'h0000_0000, 16'h7F80, 16'h0000, 16'h0000, 16'h0000, 32'h7FC0_0000);
        add_row(1'b0, 32'h0000_0000, 16'h7F80, 16'h3F80, 16'hFF80, 16'h3F80, 32'h7FC0_0000);
        add_row(1'b0, 32'h3F80_0000, 16'hFF80, 16'h4000, 16'h0000, 16'h0000, 32'hFF80_0000);
        add_row(1'b0, 32'hFF80_0000, 16'h7F80, 16'h3F80, 16'h0000, 16'h0000, 32'h7FC0_0000);
        add_row(1'b0, 32'h7F80_0000, 16'h3F80, 16'h3F80, 16'h0000, 16'h0000, 32'h7F80_0000);
        // Overflow to -Inf, then a subnormal operand flushed to zero
        add_row(1'b0, 32'h0000_0000, 16'hFF7F, 16'h4000, 16'h0000, 16'h0000, 32'hFF80_0000);
        add_row(1'b0, 32'h3F80_0000, 16'h0040, 16'h7F00, 16'h0000, 16'h0000, 32'h3F80_0000);

        repeat (10) @(negedge clk);
        arst_n = 1'b1;
        repeat (2) @(negedge clk);

        // Config for row k goes in with the request of row k-1
        for (int k = 0; k <= rows.size(); k++) begin
            @(negedge clk);
            cfg_we = (k < rows.size());
            if (k < rows.size()) begin
                cfg_data.is_int = rows[k].is_int;
                cfg_data.cval   = rows[k].cval;
            end
            in_valid = (k > 0);
            if (k > 0) begin
                row            = rows[k-1];
                in_lanes[0].a  = row.a0;
                in_lanes[0].b  = row.b0;
                in_lanes[1].a  = row.a1;
                in_lanes[1].b  = row.b1;
                exp_q.push_back(row.expv);
                issue_q.push_back(cyc);
            end
        end
        @(negedge clk);
        in_valid = 1'b0;
        cfg_we   = 1'b0;

        // Drain with a bound
        waits = 0;
        while (exp_q.size() != 0 && waits < 20) begin
            @(negedge clk);
            waits++;
        end
        if (exp_q.size() == 0) begin
            $display("Simulation PASSED");
            $finish;
        end else begin
            $display("Timeout: %0d results never came out", exp_q.size());
            abort_run();
        end
    end

endmodule

//--- vlog.f
common/fedp_pkg.sv
design/fedp_cfg_regs.sv
fedp/fedp_mul.sv
fedp/fedp_align.sv
fedp/fedp_lzc.sv
fedp/fedp_norm_round.sv
design/fedp_top.sv
testbench/fedp_tb.sv
